//--- icache_sub.f
source/cpu_types_pkg.sv
source/datapath_cache_if.sv
source/caches_if.sv
source/icache.sv
source/memory_control.sv
source/caches_top.sv
verification/caches_sva.sv
verification/caches_tb.sv

//--- Bender.yml
package:
  name: icache_sub

sources:
  - files:
      - source/cpu_types_pkg.sv
      - source/datapath_cache_if.sv
      - source/caches_if.sv
      - source/icache.sv
      - source/memory_control.sv
      - source/caches_top.sv
  - target: test
    files:
      - verification/caches_sva.sv
      - verification/caches_tb.sv

//--- verification/caches_tb.sv
// testbench for the instruction fetch memory subsystem
//   clock, reset, LCG and watchdog
//   RAM model with random BUSY latency
//   icache scoreboard, directed and random stimulus

`timescale 1ns/1ns

module caches_tb;
  import cpu_types_pkg::*;

  localparam int NUM_BLOCKS     = 16;
  localparam int RESET_CYCLES   = 10;
  localparam int MIN_LAT        = 2;
  localparam int MAX_LAT        = 4;
  localparam int RAND_OPS       = 40;
  // ten directed accesses before the random mix
  localparam int NUM_ACCESSES   = 10 + RAND_OPS;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ACCESSES * (MAX_LAT + 6);

  logic      CLK = 1'b0;
  logic      nRST;
  logic      imemren, ihit;
  addr_t     imemaddr;
  word_t     imemload;
  logic      dmemren, dmemwen, dhit;
  addr_t     dmemaddr;
  word_t     dmemstore, dmemload;
  logic      ramren, ramwen;
  addr_t     ramaddr;
  word_t     ramstore, ramload;
  ramstate_t ramstate;

  // RAM contents and model state
  word_t       ram_mem [256];
  ramstate_t   ram_state_n = FREE;
  word_t       ram_load_n  = '0;
  int unsigned ram_count;
  logic        ram_active  = 1'b0;

  // expected cache contents per index
  logic  sb_valid [NUM_BLOCKS];
  addr_t sb_addr  [NUM_BLOCKS];
  word_t sb_word  [NUM_BLOCKS];

  logic [31:0] rng = 32'd72;

  always #5 CLK = ~CLK;

  caches_top #(.NUM_BLOCKS(NUM_BLOCKS)) dut_i (
    .CLK(CLK), .nRST(nRST),
    .imemren(imemren), .imemaddr(imemaddr), .ihit(ihit), .imemload(imemload),
    .dmemren(dmemren), .dmemwen(dmemwen), .dmemaddr(dmemaddr),
    .dmemstore(dmemstore), .dhit(dhit), .dmemload(dmemload),
    .ramren(ramren), .ramwen(ramwen), .ramaddr(ramaddr), .ramstore(ramstore),
    .ramload(ramload), .ramstate(ramstate)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic draw(output logic [31:0] r);
    rng = lcg_step(rng);
    r = rng;
  endtask

  task automatic end_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp) else begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  // scoreboard fill
  // data writes never touch a frame
  task automatic sb_fill(input addr_t addr, input word_t word);
    sb_valid[(addr >> 2) % NUM_BLOCKS] = 1'b1;
    sb_addr[(addr >> 2) % NUM_BLOCKS]  = addr;
    sb_word[(addr >> 2) % NUM_BLOCKS]  = word;
  endtask

  // RAM model
  // bus sampled on the rising edge
  always @(posedge CLK) begin
    logic [31:0] r;
    if (!nRST) begin
      ram_active  = 1'b0;
      ram_state_n = FREE;
    end else if (ramstate == ACCESS) begin
      // write lands at the end of the access cycle
      if (ramwen) begin
        ram_mem[ramaddr[9:2]] = ramstore;
      end
      ram_active  = 1'b0;
      ram_state_n = FREE;
    end else if (ramren || ramwen) begin
      if (!ram_active) begin
        draw(r);
        ram_active  = 1'b1;
        ram_count   = MIN_LAT + (r >> 16) % (MAX_LAT - MIN_LAT + 1);
        ram_state_n = BUSY;
      end else if (ram_count > 1) begin
        ram_count--;
      end else begin
        ram_state_n = ACCESS;
        ram_load_n  = ram_mem[ramaddr[9:2]];
      end
    end
  end

  // RAM answer goes out on the falling edge
  always @(negedge CLK) begin
    ramstate = ram_state_n;
    ramload  = ram_load_n;
  end

  // expected hit from the scoreboard
  // expected word from the frame or from RAM
  task automatic fetch(input addr_t addr, output logic hit, output word_t word);
    int unsigned idx;
    int unsigned cycles;
    logic        pred_hit;
    logic        saw_fill;
    word_t       exp_word;
    idx      = (addr >> 2) % NUM_BLOCKS;
    pred_hit = sb_valid[idx] && (sb_addr[idx][31:2] == addr[31:2]);
    cycles   = 0;
    @(negedge CLK);
    imemren  = 1'b1;
    imemaddr = addr;
    @(posedge CLK);
    // fill request looked for in every cycle of the fetch
    saw_fill = ramren && !dmemren && !dmemwen;
    while (!ihit) begin
      cycles++;
      @(posedge CLK);
      if (ramren && !dmemren && !dmemwen) begin
        saw_fill = 1'b1;
      end
    end
    exp_word = pred_hit ? sb_word[idx] : ram_mem[addr[9:2]];
    check_word("imemload", imemload, exp_word);
    check_word("ihit in request cycle", cycles == 0, pred_hit);
    check_word("instruction ramren", saw_fill, !pred_hit);
    sb_fill(addr, exp_word);
    hit  = (cycles == 0);
    word = imemload;
    @(negedge CLK);
    imemren = 1'b0;
  endtask

  task automatic data_access(input logic wen, input addr_t addr, input word_t wdata);
    @(negedge CLK);
    dmemren   = !wen;
    dmemwen   = wen;
    dmemaddr  = addr;
    dmemstore = wdata;
    @(posedge CLK);
    while (!dhit) begin
      @(posedge CLK);
    end
    if (!wen) begin
      check_word("dmemload", dmemload, ram_mem[addr[9:2]]);
    end
    @(negedge CLK);
    dmemren = 1'b0;
    dmemwen = 1'b0;
    if (wen) begin
      check_word("RAM word after write", ram_mem[addr[9:2]], wdata);
    end
  endtask

  // instruction miss and data read raised in the same cycle
  task automatic fetch_during_data(input addr_t iaddr, input addr_t daddr);
    @(negedge CLK);
    imemren  = 1'b1;
    imemaddr = iaddr;
    dmemren  = 1'b1;
    dmemaddr = daddr;
    @(posedge CLK);
    check_word("ramaddr", ramaddr, daddr);
    while (!dhit) begin
      check_word("ihit", ihit, 1'b0);
      @(posedge CLK);
    end
    check_word("dmemload", dmemload, ram_mem[daddr[9:2]]);
    @(negedge CLK);
    dmemren = 1'b0;
    @(posedge CLK);
    // fill goes out once data leaves the bus
    check_word("ramren", ramren, 1'b1);
    check_word("ramaddr", ramaddr, iaddr);
    while (!ihit) begin
      @(posedge CLK);
    end
    check_word("imemload", imemload, ram_mem[iaddr[9:2]]);
    sb_fill(iaddr, ram_mem[iaddr[9:2]]);
    @(negedge CLK);
    imemren = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    logic        hit;
    word_t       word;
    word_t       old_word;
    nRST      = 1'b0;
    imemren   = 1'b0;
    imemaddr  = '0;
    dmemren   = 1'b0;
    dmemwen   = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    ramstate  = FREE;
    ramload   = '0;
    for (int i = 0; i < 256; i++) begin
      draw(r);
      ram_mem[i] = r;
    end
    for (int i = 0; i < NUM_BLOCKS; i++) begin
      sb_valid[i] = 1'b0;
    end
    // quiet outputs while reset is held
    repeat (RESET_CYCLES) begin
      @(posedge CLK);
      check_word("ihit", ihit, 1'b0);
      check_word("dhit", dhit, 1'b0);
      check_word("ramren", ramren, 1'b0);
      check_word("ramwen", ramwen, 1'b0);
    end
    @(negedge CLK);
    nRST = 1'b1;
    // miss then hit on one address
    fetch(32'h0000_0104, hit, word);
    check_word("first fetch hit", hit, 1'b0);
    fetch(32'h0000_0104, hit, word);
    check_word("second fetch hit", hit, 1'b1);
    // same index with another tag evicts the first line
    fetch(32'h0000_0144, hit, word);
    check_word("conflict fetch hit", hit, 1'b0);
    fetch(32'h0000_0104, hit, word);
    check_word("refetch after eviction hit", hit, 1'b0);
    // data wins the bus
    fetch_during_data(32'h0000_0208, 32'h0000_03f0);
    // a write to a cached word leaves the stale copy in the line
    fetch(32'h0000_008c, hit, old_word);
    data_access(1'b1, 32'h0000_008c, ~old_word);
    fetch(32'h0000_008c, hit, word);
    check_word("fetch after data write hit", hit, 1'b1);
    check_word("stale imemload", word, old_word);
    data_access(1'b0, 32'h0000_008c, '0);
    // random fetches over 64 words and data reads over all of RAM
    for (int n = 0; n < RAND_OPS; n++) begin
      draw(r);
      if (r[31]) begin
        fetch({24'd0, r[21:16], 2'b00}, hit, word);
      end else begin
        data_access(1'b0, {22'd0, r[23:16], 2'b00}, '0);
      end
    end
    @(negedge CLK);
    if (dut_i.caches_sva_i.fail_count != 0) begin
      $display("concurrent assertion failures in caches_sva");
      end_with_failure();
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

  // stop at the first concurrent assertion failure
  always @(negedge CLK) begin
    if (dut_i.caches_sva_i.fail_count != 0) begin
      $display("concurrent assertion failed in caches_sva");
      end_with_failure();
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("watchdog expired, run did not finish in %0d cycles", TIMEOUT_CYCLES);
    end_with_failure();
  end

endmodule

//--- verification/caches_sva.sv
// concurrent checks on the caches_top ports
//   reset quiet, request hold rules
//   data priority on the RAM bus
//   fill word returned at ihit

`timescale 1ns/1ns

module caches_sva (
  input logic                      CLK,
  input logic                      nRST,
  input logic                      imemren,
  input cpu_types_pkg::addr_t      imemaddr,
  input logic                      ihit,
  input cpu_types_pkg::word_t      imemload,
  input logic                      dmemren,
  input logic                      dmemwen,
  input cpu_types_pkg::addr_t      dmemaddr,
  input cpu_types_pkg::word_t      dmemstore,
  input logic                      dhit,
  input logic                      ramren,
  input logic                      ramwen,
  input cpu_types_pkg::addr_t      ramaddr,
  input cpu_types_pkg::word_t      ramload,
  input cpu_types_pkg::ramstate_t  ramstate
);
  import cpu_types_pkg::*;

  // failures so far
  // watched by the testbench
  int unsigned fail_count = 0;

  // strobes and RAM requests stay low in reset
  reset_quiet_a: assert property (@(posedge CLK)
    !nRST |-> !ihit && !dhit && !ramren && !ramwen)
    else begin
      fail_count++;
      $error("outputs active during reset");
    end

  // fetch held with the same address until ihit
  fetch_hold_a: assert property (@(posedge CLK) disable iff (!nRST)
    imemren && !ihit |=> imemren && $stable(imemaddr))
    else begin
      fail_count++;
      $error("fetch request dropped before ihit");
    end

  // data request held unchanged until dhit
  data_hold_a: assert property (@(posedge CLK) disable iff (!nRST)
    (dmemren || dmemwen) && !dhit
      |=> $stable({dmemren, dmemwen, dmemaddr, dmemstore}))
    else begin
      fail_count++;
      $error("data request dropped before dhit");
    end

  // a data request owns the RAM bus with no instruction fill beside it
  data_priority_a: assert property (@(posedge CLK) disable iff (!nRST)
    (dmemren || dmemwen)
      |-> ramaddr == dmemaddr && ramren == dmemren && ramwen == dmemwen)
    else begin
      fail_count++;
      $error("RAM bus not given to data request");
    end

  // fill word shows up at ihit one cycle later
  fill_word_a: assert property (@(posedge CLK) disable iff (!nRST)
    ramren && !dmemren && !dmemwen && ramstate == ACCESS
      |=> ihit && imemload == $past(ramload))
    else begin
      fail_count++;
      $error("fill word not returned at ihit");
    end

endmodule

bind caches_top caches_sva caches_sva_i (.*);

//--- source/caches_top.sv
// top level of the instruction fetch memory subsystem
//   plain fetch, data and RAM bus ports
//   fetch channel and fill channel interfaces
//   icache and memory_control instances

`timescale 1ns/1ns

module caches_top #(
  parameter int unsigned NUM_BLOCKS = 16
) (
  input  logic                      CLK,
  input  logic                      nRST,

  // instruction fetch
  input  logic                      imemren,
  input  cpu_types_pkg::addr_t      imemaddr,
  output logic                      ihit,
  output cpu_types_pkg::word_t      imemload,

  // uncached data port
  input  logic                      dmemren,
  input  logic                      dmemwen,
  input  cpu_types_pkg::addr_t      dmemaddr,
  input  cpu_types_pkg::word_t      dmemstore,
  output logic                      dhit,
  output cpu_types_pkg::word_t      dmemload,

  // external RAM bus
  output logic                      ramren,
  output logic                      ramwen,
  output cpu_types_pkg::addr_t      ramaddr,
  output cpu_types_pkg::word_t      ramstore,
  input  cpu_types_pkg::word_t      ramload,
  input  cpu_types_pkg::ramstate_t  ramstate
);

  // fetch channel, top ports to icache
  datapath_cache_if dcif ();

  // fill channel, icache to controller
  caches_if cif ();

  // fetch request in
  assign dcif.imemren  = imemren;
  assign dcif.imemaddr = imemaddr;

  // fetch response out
  assign ihit     = dcif.ihit;
  assign imemload = dcif.imemload;

  icache #(
    .NUM_BLOCKS (NUM_BLOCKS)
  ) icache_i (
    .CLK  (CLK),
    .nRST (nRST),
    .dcif (dcif),
    .cif  (cif)
  );

  // combinational, no clock or reset
  memory_control memory_control_i (
    .cif       (cif),
    .dmemren   (dmemren),
    .dmemwen   (dmemwen),
    .dmemaddr  (dmemaddr),
    .dmemstore (dmemstore),
    .dhit      (dhit),
    .dmemload  (dmemload),
    .ramren    (ramren),
    .ramwen    (ramwen),
    .ramaddr   (ramaddr),
    .ramstore  (ramstore),
    .ramload   (ramload),
    .ramstate  (ramstate)
  );

endmodule

//--- source/memory_control.sv
// memory controller for the fetch side
//   arbiter between icache fills and the uncached data port
//   data requests always win
//   drives the single external RAM bus
//   iwait and dhit derived from ramstate and the grant

`timescale 1ns/1ns

module memory_control (
  caches_if.ctrl                    cif,

  // uncached data port
  input  logic                      dmemren,
  input  logic                      dmemwen,
  input  cpu_types_pkg::addr_t      dmemaddr,
  input  cpu_types_pkg::word_t      dmemstore,
  output logic                      dhit,
  output cpu_types_pkg::word_t      dmemload,

  // external RAM bus
  output logic                      ramren,
  output logic                      ramwen,
  output cpu_types_pkg::addr_t      ramaddr,
  output cpu_types_pkg::word_t      ramstore,
  input  cpu_types_pkg::word_t      ramload,
  input  cpu_types_pkg::ramstate_t  ramstate
);
  import cpu_types_pkg::*;

  // data side owns the bus this cycle
  logic dgrant;
  // instruction side owns the bus this cycle
  logic igrant;
  // RAM finished the current access
  logic ram_done;

  // any data request takes the bus
  assign dgrant = dmemren || dmemwen;

  // fill goes out only when data is absent
  assign igrant = cif.iren && !dgrant;

  // ERROR is never treated as done
  // requester keeps waiting
  assign ram_done = (ramstate == ACCESS);

  // RAM bus from the winner
  always_comb begin
    ramren   = 1'b0;
    ramwen   = 1'b0;
    ramaddr  = cif.iaddr;
    ramstore = dmemstore;
    if (dgrant) begin
      ramren  = dmemren;
      ramwen  = dmemwen;
      ramaddr = dmemaddr;
    end else if (igrant) begin
      ramren = 1'b1;
    end
  end

  // data done when RAM reports ACCESS under a data grant
  assign dhit = dgrant && ram_done;

  // fill stalls while data holds the bus or RAM is not done
  assign cif.iwait = dgrant || !ram_done;

  // read data to both sides
  // each side only samples it on its own strobe
  assign cif.iload = ramload;
  assign dmemload  = ramload;

endmodule

//--- source/icache.sv
// direct-mapped instruction cache
//   NUM_BLOCKS frames of valid bit, tag and one word
//   combinational hit path
//   two-state miss controller, IDLE and REQUEST

`timescale 1ns/1ns

module icache #(
  parameter int unsigned NUM_BLOCKS = 16
) (
  input  logic            CLK,
  input  logic            nRST,
  datapath_cache_if.cache dcif,
  caches_if.cache         cif
);
  import cpu_types_pkg::*;

  // address split: tag | index | byte offset
  localparam int OFF_W = $clog2(WORD_BYTES);
  localparam int IDX_W = $clog2(NUM_BLOCKS);
  localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  // miss controller states
  typedef enum logic {
    IDLE    = 1'b0,
    REQUEST = 1'b1
  } state_t;

  // frame storage
  logic [NUM_BLOCKS-1:0] valid_q;
  tag_t                  tag_q  [NUM_BLOCKS];
  word_t                 data_q [NUM_BLOCKS];

  // decoded request address
  idx_t idx;
  tag_t tag;

  // lookup result
  logic hit;

  // frame write strobe, fill word arrived
  logic fill;

  state_t state_q, state_d;

  // fields of the fetch address
  // byte offset bits are dropped
  assign idx = dcif.imemaddr[OFF_W +: IDX_W];
  assign tag = dcif.imemaddr[ADDR_W-1 -: TAG_W];

  // hit needs a live request, a valid frame and a tag match
  // a frame being filled is still invalid, so no hit in REQUEST
  assign hit = dcif.imemren && valid_q[idx] && (tag_q[idx] == tag);

  assign dcif.ihit     = hit;
  assign dcif.imemload = data_q[idx];

  // fill address is the held fetch address
  assign cif.iaddr = dcif.imemaddr;

  // request only while waiting on memory
  assign cif.iren = (state_q == REQUEST);

  // word is valid in the cycle iwait drops
  assign fill = (state_q == REQUEST) && !cif.iwait;

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // miss on a live request starts a fill
        if (dcif.imemren && !hit) begin
          state_d = REQUEST;
        end
      end
      REQUEST: begin
        // back to lookup once the word is in
        // datapath then hits on the following cycle
        if (!cif.iwait) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // controller state
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // valid bits, all lines invalid out of reset
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= '0;
    end else if (fill) begin
      valid_q[idx] <= 1'b1;
    end
  end

  // tag and word of the frame being filled
  // qualified by valid, so contents after reset do not matter
  always_ff @(posedge CLK) begin
    if (fill) begin
      tag_q[idx]  <= tag;
      data_q[idx] <= cif.iload;
    end
  end

endmodule

//--- source/caches_if.sv
// line fill channel between instruction cache and memory controller
//   request: iren, iaddr
//   response: iwait, iload
//   modports for the cache and controller ends

`timescale 1ns/1ns

interface caches_if;
  import cpu_types_pkg::*;

  // fill request from the cache
  // held until a cycle with iwait low
  logic  iren;
  addr_t iaddr;

  // stall while the RAM bus is busy or taken by data
  logic  iwait;
  // fill word, valid when iwait is low
  word_t iload;

  // cache end
  modport cache (
    output iren,
    output iaddr,
    input  iwait,
    input  iload
  );

  // memory controller end
  modport ctrl (
    input  iren,
    input  iaddr,
    output iwait,
    output iload
  );

endinterface

//--- source/datapath_cache_if.sv
// fetch channel between datapath side and instruction cache
//   request: imemren, imemaddr
//   response: ihit, imemload
//   modports for the cache and the datapath side

`timescale 1ns/1ns

interface datapath_cache_if;
  import cpu_types_pkg::*;

  // fetch request, held until ihit
  logic  imemren;
  addr_t imemaddr;

  // hit strobe, transfer completes in this cycle
  logic  ihit;
  // instruction word, valid with ihit
  word_t imemload;

  // cache end
  modport cache (
    input  imemren,
    input  imemaddr,
    output ihit,
    output imemload
  );

  // requester end, the top level in this design
  modport datapath (
    output imemren,
    output imemaddr,
    input  ihit,
    input  imemload
  );

endinterface

//--- source/cpu_types_pkg.sv
// shared types for the instruction fetch memory subsystem
//   word and byte address types
//   external RAM bus state encoding
//   bytes per word, for address field sizing

package cpu_types_pkg;

  // datapath width
  localparam int WORD_W = 32;

  // address width, byte addressed
  localparam int ADDR_W = 32;

  // bytes in one word
  // low address bits below this are the byte offset
  localparam int WORD_BYTES = WORD_W / 8;

  // one data or instruction word
  typedef logic [WORD_W-1:0] word_t;

  // byte address, word aligned
  // low 2 bits are ignored by every consumer
  typedef logic [ADDR_W-1:0] addr_t;

  // condition reported by the external RAM each cycle
  typedef enum logic [1:0] {
    // idle, nothing requested
    FREE   = 2'b00,
    // access in progress
    BUSY   = 2'b01,
    // read data valid or write done this cycle
    ACCESS = 2'b10,
    // bad access
    ERROR  = 2'b11
  } ramstate_t;

endpackage
